/* Makefile */
VERILATOR  ?= verilator
TOP        := rdma_resp_gen_tb
RTL_TOP    := rdma_resp_gen
FILELIST   := rdma_resp_gen.f
OBJ_DIR    := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert -j 0 --Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TB FAILED" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* rdma_resp_gen.f */
source/rdma_resp_pkg.sv
source/rdma_req_decode.sv
source/rdma_hdr_execute.sv
source/rdma_beat_result.sv
source/rdma_resp_gen.sv
verif/tb_clk_gen.sv
verif/rdma_resp_gen_props.sv
verif/rdma_resp_gen_tb.sv

/* source/rdma_beat_result.sv */
`timescale 1ns/10ps
`default_nettype none

module rdma_beat_result (
  input  wire                         core_clk,
  input  wire                         core_aresetn,
  input  wire rdma_resp_pkg::pkt_t    pkt_i,
  input  wire                         pkt_req_i,
  output logic                        pkt_ack_o,
  output rdma_resp_pkg::beat_t        m_tdata_o,
  output rdma_resp_pkg::keep_t        m_tkeep_o,
  output logic                        m_tvalid_o,
  output logic                        m_tlast_o,
  input  wire                         m_tready_i,
  output logic [7:0]                  rd_resp_cnt_o,
  output logic [7:0]                  ack_cnt_o
);

  localparam logic [8:0] RD_LEN  = 9'(rdma_resp_pkg::HDR_BYTES + rdma_resp_pkg::RD_PAYLOAD_BYTES);
  localparam logic [8:0] ACK_LEN = 9'(rdma_resp_pkg::HDR_BYTES);
  localparam logic [8:0] BEAT_LEN = 9'(rdma_resp_pkg::BEAT_BYTES);

  typedef enum logic [1:0] {
    R_IDLE,
    R_LOAD,
    R_SEND
  } res_state_t;

  res_state_t                 state_q;
  logic                       ack_q;
  logic [2:0]                 idx_q;   // next beat to load
  logic [8:0]                 rem_q;   // bytes not yet loaded
  rdma_resp_pkg::hdr_t        hdr_q;
  logic [7:0]                 pay_q;
  rdma_resp_pkg::resp_kind_t  kind_q;
  logic                       pkt_take;
  logic                       load_beat;
  rdma_resp_pkg::beat_t       raw_beat;
  rdma_resp_pkg::beat_t       nxt_data;
  rdma_resp_pkg::keep_t       nxt_keep;
  logic                       nxt_last;

  assign pkt_take  = (state_q == R_IDLE) && pkt_req_i && !ack_q;
  assign pkt_ack_o = ack_q;
  assign load_beat = (state_q == R_LOAD) ||
                     ((state_q == R_SEND) && m_tready_i && !m_tlast_o);

  // header only ever lands in beat 0
  assign raw_beat = (idx_q == 3'd0) ?
                    {{(rdma_resp_pkg::BEAT_BYTES-rdma_resp_pkg::HDR_BYTES){pay_q}}, hdr_q} :
                    {rdma_resp_pkg::BEAT_BYTES{pay_q}};

  assign nxt_last = (rem_q <= BEAT_LEN);
  assign nxt_keep = nxt_last ? ~({rdma_resp_pkg::BEAT_BYTES{1'b1}} << rem_q[5:0]) : '1;

  always_comb begin
    for (int l = 0; l < rdma_resp_pkg::BEAT_BYTES; l++) begin
      nxt_data[8*l +: 8] = nxt_keep[l] ? raw_beat[8*l +: 8] : 8'h00;
    end
  end

  always_ff @(posedge core_clk) begin
    if (pkt_take) begin
      hdr_q  <= pkt_i.hdr;
      pay_q  <= pkt_i.payload;
      kind_q <= pkt_i.kind;
    end
    if (load_beat) begin
      m_tdata_o <= nxt_data;
      m_tkeep_o <= nxt_keep;
    end
  end

  always_ff @(posedge core_clk or negedge core_aresetn) begin
    if (!core_aresetn) begin
      state_q       <= R_IDLE;
      ack_q         <= 1'b0;
      idx_q         <= '0;
      rem_q         <= '0;
      m_tvalid_o    <= 1'b0;
      m_tlast_o     <= 1'b0;
      rd_resp_cnt_o <= '0;
      ack_cnt_o     <= '0;
    end else begin
      if (pkt_take) begin
        ack_q <= 1'b1;
      end else if (ack_q && !pkt_req_i) begin
        ack_q <= 1'b0;
      end
      if (load_beat) begin
        m_tlast_o <= nxt_last;
        idx_q     <= idx_q + 3'd1;
        rem_q     <= nxt_last ? 9'd0 : rem_q - BEAT_LEN;
      end
      case (state_q)
        R_IDLE: begin
          if (pkt_take) begin
            state_q <= R_LOAD;
            idx_q   <= '0;
            rem_q   <= (pkt_i.kind == rdma_resp_pkg::RESP_RD) ? RD_LEN : ACK_LEN;
          end
        end
        R_LOAD: begin
          m_tvalid_o <= 1'b1;
          state_q    <= R_SEND;
        end
        R_SEND: begin
          if (m_tready_i && m_tlast_o) begin
            m_tvalid_o <= 1'b0;
            m_tlast_o  <= 1'b0;
            state_q    <= R_IDLE;
            if (kind_q == rdma_resp_pkg::RESP_RD) begin
              rd_resp_cnt_o <= rd_resp_cnt_o + 8'd1;
            end else begin
              ack_cnt_o <= ack_cnt_o + 8'd1;
            end
          end
        end
        default: state_q <= R_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* source/rdma_hdr_execute.sv */
`timescale 1ns/10ps
`default_nettype none

module rdma_hdr_execute (
  input  wire                             core_clk,
  input  wire                             core_aresetn,
  input  wire rdma_resp_pkg::local_cfg_t  local_cfg_i,
  input  wire rdma_resp_pkg::resp_job_t   job_i,
  input  wire                             job_req_i,
  output logic                            job_ack_o,
  output rdma_resp_pkg::pkt_t             pkt_o,
  output logic                            pkt_req_o,
  input  wire                             pkt_ack_i
);

  typedef enum logic [1:0] {
    X_IDLE,
    X_BUILD,
    X_OFFER,
    X_RELEASE
  } exe_state_t;

  exe_state_t                state_q;
  logic                      ack_q;
  rdma_resp_pkg::resp_job_t  job_q;
  rdma_resp_pkg::pkt_t       pkt_q;
  logic                      job_take;
  logic                      is_rd;
  rdma_resp_pkg::opcode_t    resp_op;
  logic [15:0]               ip_total;
  logic [15:0]               udp_len;
  rdma_resp_pkg::ipv4_hdr_t  ip_hdr;
  logic [15:0]               ip_csum;
  rdma_resp_pkg::hdr_t       hdr_be;    // first wire byte on top
  rdma_resp_pkg::hdr_t       hdr_lane;

  assign job_take  = (state_q == X_IDLE) && job_req_i && !ack_q;
  assign job_ack_o = ack_q;
  assign pkt_req_o = (state_q == X_OFFER);
  assign pkt_o     = pkt_q;

  assign is_rd    = (job_q.kind == rdma_resp_pkg::RESP_RD);
  assign resp_op  = is_rd ? rdma_resp_pkg::OPC_RD_RESP : rdma_resp_pkg::OPC_ACK;
  assign ip_total = is_rd ? rdma_resp_pkg::IP_TOTAL_RD : rdma_resp_pkg::IP_TOTAL_ACK;
  assign udp_len  = ip_total - 16'd20;

  // checksum word left at zero for the sum
  assign ip_hdr = {8'h45, 8'hb8, ip_total, 16'h5555, 16'h4000, 8'hba, 8'h11,
                   16'h0000, local_cfg_i.src_ip, job_q.cfg.dst_ip};

  assign ip_csum = ~rdma_resp_pkg::ipv4_checksum(ip_hdr);

  assign hdr_be = {job_q.cfg.dst_mac,
                   local_cfg_i.src_mac,
                   16'h0800,
                   ip_hdr[159:80], ip_csum, ip_hdr[63:0],
                   rdma_resp_pkg::UDP_SRC_PORT,
                   rdma_resp_pkg::UDP_DST_PORT,
                   udp_len,
                   16'h0000,
                   resp_op, 8'h00, rdma_resp_pkg::PKEY,
                   8'h00, job_q.qpn,
                   8'h00, job_q.psn,
                   32'h0000_0000};  // AETH

  // byte 0 of the wire goes to lane 0
  always_comb begin
    for (int i = 0; i < rdma_resp_pkg::HDR_BYTES; i++) begin
      hdr_lane[8*i +: 8] = hdr_be[8*(rdma_resp_pkg::HDR_BYTES-1-i) +: 8];
    end
  end

  always_ff @(posedge core_clk) begin
    if (job_take) begin
      job_q <= job_i;
    end
    if (state_q == X_BUILD) begin
      pkt_q.hdr     <= hdr_lane;
      pkt_q.payload <= is_rd ? job_q.psn[7:0] : 8'h00;
      pkt_q.kind    <= job_q.kind;
    end
  end

  always_ff @(posedge core_clk or negedge core_aresetn) begin
    if (!core_aresetn) begin
      state_q <= X_IDLE;
      ack_q   <= 1'b0;
    end else begin
      if (job_take) begin
        ack_q <= 1'b1;
      end else if (ack_q && !job_req_i) begin
        ack_q <= 1'b0;
      end
      case (state_q)
        X_IDLE: begin
          if (job_take) begin
            state_q <= X_BUILD;
          end
        end
        X_BUILD: state_q <= X_OFFER;
        X_OFFER: begin
          if (pkt_ack_i) begin
            state_q <= X_RELEASE;
          end
        end
        X_RELEASE: begin
          if (!pkt_ack_i) begin
            state_q <= X_IDLE;
          end
        end
        default: state_q <= X_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* source/rdma_req_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module rdma_req_decode #(
  parameter int NUM_QP = 6
) (
  input  wire                          core_clk,
  input  wire                          core_aresetn,
  input  wire                          enable_i,
  input  wire rdma_resp_pkg::beat_t    req_tdata_i,
  input  wire                          req_tvalid_i,
  input  wire                          req_tlast_i,
  output logic                         req_tready_o,
  input  wire rdma_resp_pkg::qp_cfg_t  qp_table_i [NUM_QP],
  output rdma_resp_pkg::resp_job_t     job_o,
  output logic                         job_req_o,
  input  wire                          job_ack_i
);

  localparam int IDX_W = (NUM_QP > 1) ? $clog2(NUM_QP) : 1;

  typedef enum logic [2:0] {
    IDLE,
    SKIP,
    LOOKUP,
    OFFER,
    RELEASE
  } dec_state_t;

  dec_state_t                state_q;
  logic                      tail_q;  // more beats follow the header beat
  rdma_resp_pkg::opcode_t    op_q;
  rdma_resp_pkg::psn_t       psn_q;
  rdma_resp_pkg::qpn_t       qpn_q;
  rdma_resp_pkg::resp_job_t  job_q;
  logic                      beat_acc;
  logic                      op_known;
  logic                      qp_hit;
  logic [IDX_W-1:0]          qp_idx;

  assign req_tready_o = enable_i && ((state_q == IDLE) || (state_q == SKIP));
  assign beat_acc     = req_tvalid_i && req_tready_o;
  assign job_req_o    = (state_q == OFFER);
  assign job_o        = job_q;

  assign op_known = (op_q == rdma_resp_pkg::OPC_RD_REQ) ||
                    (op_q == rdma_resp_pkg::OPC_WR_ONLY);
  assign qp_hit   = (qpn_q < rdma_resp_pkg::qpn_t'(NUM_QP));
  assign qp_idx   = qpn_q[IDX_W-1:0];

  // header fields, big-endian on the wire
  always_ff @(posedge core_clk) begin
    if ((state_q == IDLE) && beat_acc) begin
      op_q  <= req_tdata_i[8*rdma_resp_pkg::OPC_OFS +: 8];
      qpn_q <= {req_tdata_i[8*rdma_resp_pkg::QPN_OFS +: 8],
                req_tdata_i[8*(rdma_resp_pkg::QPN_OFS+1) +: 8],
                req_tdata_i[8*(rdma_resp_pkg::QPN_OFS+2) +: 8]};
      psn_q <= {req_tdata_i[8*rdma_resp_pkg::PSN_OFS +: 8],
                req_tdata_i[8*(rdma_resp_pkg::PSN_OFS+1) +: 8],
                req_tdata_i[8*(rdma_resp_pkg::PSN_OFS+2) +: 8]};
    end
    if ((state_q == LOOKUP) && op_known && qp_hit) begin
      job_q.kind <= (op_q == rdma_resp_pkg::OPC_RD_REQ) ? rdma_resp_pkg::RESP_RD :
                                                          rdma_resp_pkg::RESP_ACK;
      job_q.psn  <= psn_q;
      job_q.qpn  <= qpn_q;
      job_q.cfg  <= qp_table_i[qp_idx];
    end
  end

  always_ff @(posedge core_clk or negedge core_aresetn) begin
    if (!core_aresetn) begin
      state_q <= IDLE;
      tail_q  <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (beat_acc) begin
            state_q <= LOOKUP;
            tail_q  <= !req_tlast_i;
          end
        end
        LOOKUP: begin
          if (op_known && qp_hit) begin
            state_q <= OFFER;
          end else begin
            state_q <= tail_q ? SKIP : IDLE;  // dropped request
          end
        end
        OFFER: begin
          if (job_ack_i) begin
            state_q <= RELEASE;
          end
        end
        RELEASE: begin
          if (!job_ack_i) begin
            state_q <= tail_q ? SKIP : IDLE;
          end
        end
        SKIP: begin
          if (beat_acc && req_tlast_i) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* source/rdma_resp_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module rdma_resp_gen #(
  parameter int NUM_QP = 6
) (
  input  wire                             core_clk,
  input  wire                             core_aresetn,
  input  wire                             enable_i,
  input  wire rdma_resp_pkg::local_cfg_t  local_cfg_i,
  input  wire rdma_resp_pkg::qp_cfg_t     qp_table_i [NUM_QP],
  input  wire rdma_resp_pkg::beat_t       req_tdata_i,
  input  wire                             req_tvalid_i,
  input  wire                             req_tlast_i,
  output logic                            req_tready_o,
  output rdma_resp_pkg::beat_t            m_tdata_o,
  output rdma_resp_pkg::keep_t            m_tkeep_o,
  output logic                            m_tvalid_o,
  output logic                            m_tlast_o,
  input  wire                             m_tready_i,
  output logic [7:0]                      rd_resp_cnt_o,
  output logic [7:0]                      ack_cnt_o
);

  rdma_resp_pkg::resp_job_t  job;
  logic                      job_req;
  logic                      job_ack;
  rdma_resp_pkg::pkt_t       pkt;
  logic                      pkt_req;
  logic                      pkt_ack;

  rdma_req_decode #(
    .NUM_QP (NUM_QP)
  ) u_decode (
    .core_clk     (core_clk),
    .core_aresetn (core_aresetn),
    .enable_i     (enable_i),
    .req_tdata_i  (req_tdata_i),
    .req_tvalid_i (req_tvalid_i),
    .req_tlast_i  (req_tlast_i),
    .req_tready_o (req_tready_o),
    .qp_table_i   (qp_table_i),
    .job_o        (job),
    .job_req_o    (job_req),
    .job_ack_i    (job_ack)
  );

  rdma_hdr_execute u_execute (
    .core_clk     (core_clk),
    .core_aresetn (core_aresetn),
    .local_cfg_i  (local_cfg_i),
    .job_i        (job),
    .job_req_i    (job_req),
    .job_ack_o    (job_ack),
    .pkt_o        (pkt),
    .pkt_req_o    (pkt_req),
    .pkt_ack_i    (pkt_ack)
  );

  rdma_beat_result u_result (
    .core_clk      (core_clk),
    .core_aresetn  (core_aresetn),
    .pkt_i         (pkt),
    .pkt_req_i     (pkt_req),
    .pkt_ack_o     (pkt_ack),
    .m_tdata_o     (m_tdata_o),
    .m_tkeep_o     (m_tkeep_o),
    .m_tvalid_o    (m_tvalid_o),
    .m_tlast_o     (m_tlast_o),
    .m_tready_i    (m_tready_i),
    .rd_resp_cnt_o (rd_resp_cnt_o),
    .ack_cnt_o     (ack_cnt_o)
  );

endmodule

`default_nettype wire

/* source/rdma_resp_pkg.sv */
`default_nettype none

package rdma_resp_pkg;

  localparam int unsigned HDR_BYTES        = 58;
  localparam int unsigned RD_PAYLOAD_BYTES = 256;
  localparam int unsigned BEAT_BYTES       = 64;

  typedef logic [47:0]             mac_addr_t;
  typedef logic [31:0]             ipv4_addr_t;
  typedef logic [23:0]             psn_t;
  typedef logic [23:0]             qpn_t;
  typedef logic [7:0]              opcode_t;
  typedef logic [8*BEAT_BYTES-1:0] beat_t;
  typedef logic [BEAT_BYTES-1:0]   keep_t;
  typedef logic [8*HDR_BYTES-1:0]  hdr_t;       // wire byte i sits at [8*i +: 8]
  typedef logic [159:0]            ipv4_hdr_t;  // 20 bytes, first byte on top

  typedef enum logic {
    RESP_RD,
    RESP_ACK
  } resp_kind_t;

  typedef struct packed {
    mac_addr_t  src_mac;
    ipv4_addr_t src_ip;
  } local_cfg_t;

  typedef struct packed {
    mac_addr_t  dst_mac;
    ipv4_addr_t dst_ip;
  } qp_cfg_t;

  typedef struct packed {
    resp_kind_t kind;
    psn_t       psn;
    qpn_t       qpn;
    qp_cfg_t    cfg;
  } resp_job_t;

  typedef struct packed {
    hdr_t       hdr;
    logic [7:0] payload;
    resp_kind_t kind;
  } pkt_t;

  // BTH opcodes, RC transport
  localparam opcode_t OPC_RD_REQ  = 8'h0C;
  localparam opcode_t OPC_WR_ONLY = 8'h0A;
  localparam opcode_t OPC_RD_RESP = 8'h10;
  localparam opcode_t OPC_ACK     = 8'h11;

  localparam logic [15:0] IP_TOTAL_RD  = 16'h0130;
  localparam logic [15:0] IP_TOTAL_ACK = 16'h0030;
  localparam logic [15:0] UDP_SRC_PORT = 16'h6851;
  localparam logic [15:0] UDP_DST_PORT = 16'h12b7;
  localparam logic [15:0] PKEY         = 16'h666f;

  // request beat byte offsets
  localparam int unsigned OPC_OFS = 42;
  localparam int unsigned QPN_OFS = 47;
  localparam int unsigned PSN_OFS = 51;

  // folded ones-complement sum; the header field is its inverse
  function automatic logic [15:0] ipv4_checksum(input ipv4_hdr_t ip_hdr);
    logic [19:0] sum;
    sum = '0;
    for (int i = 0; i < 10; i++) begin
      sum = sum + {4'h0, ip_hdr[16*i +: 16]};
    end
    sum = {4'h0, sum[15:0]} + {16'h0, sum[19:16]};
    sum = {4'h0, sum[15:0]} + {19'h0, sum[16]};  // second carry at most one bit
    return sum[15:0];
  endfunction

endpackage

`default_nettype wire

/* verif/rdma_resp_gen_props.sv */
`timescale 1ns/10ps
`default_nettype none

module rdma_resp_gen_props (
  input wire                        core_clk,
  input wire                        core_aresetn,
  input wire                        hs_req_i,
  input wire                        hs_ack_i,
  input wire                        tvalid_i,
  input wire                        tready_i,
  input wire                        tlast_i,
  input wire rdma_resp_pkg::beat_t  tdata_i,
  input wire rdma_resp_pkg::keep_t  tkeep_i
);

  valid_held: assert property (@(posedge core_clk) disable iff (!core_aresetn)
    tvalid_i && !tready_i |=> tvalid_i)
    else $error("tvalid dropped before tready");

  stall_stable: assert property (@(posedge core_clk) disable iff (!core_aresetn)
    tvalid_i && !tready_i |=> $stable(tdata_i) && $stable(tkeep_i) && $stable(tlast_i))
    else $error("stream changed during a stall");

  last_in_valid: assert property (@(posedge core_clk) disable iff (!core_aresetn)
    tlast_i |-> tvalid_i)
    else $error("tlast seen without tvalid");

  // four-phase order
  req_held: assert property (@(posedge core_clk) disable iff (!core_aresetn)
    hs_req_i && !hs_ack_i |=> hs_req_i)
    else $error("req dropped before ack");

  ack_on_req: assert property (@(posedge core_clk) disable iff (!core_aresetn)
    $rose(hs_ack_i) |-> hs_req_i)
    else $error("ack rose without req");

  req_after_ack: assert property (@(posedge core_clk) disable iff (!core_aresetn)
    $rose(hs_req_i) |-> !hs_ack_i)
    else $error("req rose while ack still high");

  ack_after_req: assert property (@(posedge core_clk) disable iff (!core_aresetn)
    $fell(hs_ack_i) |-> !hs_req_i)
    else $error("ack fell while req still high");

endmodule

bind rdma_beat_result rdma_resp_gen_props u_props (
  .core_clk     (core_clk),
  .core_aresetn (core_aresetn),
  .hs_req_i     (pkt_req_i),
  .hs_ack_i     (pkt_ack_o),
  .tvalid_i     (m_tvalid_o),
  .tready_i     (m_tready_i),
  .tlast_i      (m_tlast_o),
  .tdata_i      (m_tdata_o),
  .tkeep_i      (m_tkeep_o)
);

// request stream into decode and the job handshake
bind rdma_req_decode rdma_resp_gen_props u_props (
  .core_clk     (core_clk),
  .core_aresetn (core_aresetn),
  .hs_req_i     (job_req_o),
  .hs_ack_i     (job_ack_i),
  .tvalid_i     (req_tvalid_i),
  .tready_i     (req_tready_o),
  .tlast_i      (req_tlast_i),
  .tdata_i      (req_tdata_i),
  .tkeep_i      ('1)  // no keep on the request side
);

`default_nettype wire

/* verif/rdma_resp_gen_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module rdma_resp_gen_tb;

  localparam int MAX_CYCLES = 5000;  // all tests take well under 1000 cycles

  logic                       core_clk;
  logic                       core_aresetn;
  logic                       enable_i;
  rdma_resp_pkg::local_cfg_t  local_cfg;
  rdma_resp_pkg::qp_cfg_t     qp_table [6];
  rdma_resp_pkg::beat_t       req_tdata_i;
  logic                       req_tvalid_i;
  logic                       req_tlast_i;
  logic                       req_tready_o;
  rdma_resp_pkg::beat_t       m_tdata_o;
  rdma_resp_pkg::keep_t       m_tkeep_o;
  logic                       m_tvalid_o;
  logic                       m_tlast_o;
  logic                       m_tready_i;
  logic [7:0]                 rd_resp_cnt_o;
  logic [7:0]                 ack_cnt_o;

  integer                     seed;
  logic                       rand_ready;
  int                         errors;
  int                         beats_seen;
  int                         exp_rd;
  int                         exp_ack;
  int                         cycles;
  rdma_resp_pkg::psn_t        psn_tab [12];
  rdma_resp_pkg::beat_t       exp_data [$];
  rdma_resp_pkg::keep_t       exp_keep [$];
  logic                       exp_last [$];
  rdma_resp_pkg::beat_t       e_data;
  rdma_resp_pkg::keep_t       e_keep;
  logic                       e_last;
  rdma_resp_pkg::beat_t       e_mask;

  tb_clk_gen u_clk_gen (
    .core_clk     (core_clk),
    .core_aresetn (core_aresetn)
  );

  rdma_resp_gen #(
    .NUM_QP (6)
  ) DUT (
    .core_clk      (core_clk),
    .core_aresetn  (core_aresetn),
    .enable_i      (enable_i),
    .local_cfg_i   (local_cfg),
    .qp_table_i    (qp_table),
    .req_tdata_i   (req_tdata_i),
    .req_tvalid_i  (req_tvalid_i),
    .req_tlast_i   (req_tlast_i),
    .req_tready_o  (req_tready_o),
    .m_tdata_o     (m_tdata_o),
    .m_tkeep_o     (m_tkeep_o),
    .m_tvalid_o    (m_tvalid_o),
    .m_tlast_o     (m_tlast_o),
    .m_tready_i    (m_tready_i),
    .rd_resp_cnt_o (rd_resp_cnt_o),
    .ack_cnt_o     (ack_cnt_o)
  );

  function automatic logic [15:0] ip_header_sum(input logic [15:0] total,
                                                input logic [31:0] sip,
                                                input logic [31:0] dip);
    logic [31:0] s;
    s = 32'h45b8 + 32'(total) + 32'h5555 + 32'h4000 + 32'hba11 +
        32'(sip[31:16]) + 32'(sip[15:0]) + 32'(dip[31:16]) + 32'(dip[15:0]);
    while (s[31:16] != 16'h0) begin
      s = 32'(s[15:0]) + 32'(s[31:16]);
    end
    return ~s[15:0];
  endfunction

  function automatic rdma_resp_pkg::beat_t keep_to_mask(input rdma_resp_pkg::keep_t k);
    rdma_resp_pkg::beat_t m;
    for (int l = 0; l < 64; l++) begin
      m[8*l +: 8] = {8{k[l]}};
    end
    return m;
  endfunction

  function automatic rdma_resp_pkg::beat_t make_req(input logic [7:0] opc, input logic [23:0] qpn,
                                                    input logic [23:0] psn);
    rdma_resp_pkg::beat_t b;
    b = '0;
    b[8*42 +: 8] = opc;
    b[8*47 +: 24] = {qpn[7:0], qpn[15:8], qpn[23:16]};  // big-endian on the wire
    b[8*51 +: 24] = {psn[7:0], psn[15:8], psn[23:16]};
    return b;
  endfunction

  // reference model of one response packet
  task automatic expect_response(input logic is_rd, input logic [23:0] qpn,
                                 input logic [23:0] psn);
    logic [7:0]             hb [58];
    logic [15:0]            total;
    logic [15:0]            csum;
    logic [15:0]            udp_len;
    rdma_resp_pkg::qp_cfg_t qc;
    rdma_resp_pkg::beat_t   d;
    rdma_resp_pkg::keep_t   k;
    int                     n_bytes;
    int                     n_beats;
    int                     pos;
    qc      = qp_table[qpn[2:0]];
    total   = is_rd ? 16'h0130 : 16'h0030;
    udp_len = total - 16'd20;
    csum    = ip_header_sum(total, local_cfg.src_ip, qc.dst_ip);
    for (int i = 0; i < 6; i++) begin
      hb[i]     = qc.dst_mac[8*(5-i) +: 8];
      hb[6 + i] = local_cfg.src_mac[8*(5-i) +: 8];
    end
    {hb[12], hb[13], hb[14], hb[15]} = 32'h0800_45b8;
    {hb[16], hb[17], hb[18], hb[19]} = {total, 16'h5555};
    {hb[20], hb[21], hb[22], hb[23]} = 32'h4000_ba11;
    {hb[24], hb[25]} = csum;
    for (int i = 0; i < 4; i++) begin
      hb[26 + i] = local_cfg.src_ip[8*(3-i) +: 8];
      hb[30 + i] = qc.dst_ip[8*(3-i) +: 8];
    end
    {hb[34], hb[35], hb[36], hb[37]} = 32'h6851_12b7;
    {hb[38], hb[39], hb[40], hb[41]} = {udp_len, 16'h0000};
    {hb[42], hb[43], hb[44], hb[45]} = {(is_rd ? 8'h10 : 8'h11), 8'h00, 16'h666f};
    {hb[46], hb[47], hb[48], hb[49]} = {8'h00, qpn};
    {hb[50], hb[51], hb[52], hb[53]} = {8'h00, psn};
    {hb[54], hb[55], hb[56], hb[57]} = 32'h0;  // AETH
    n_bytes = is_rd ? 58 + 256 : 58;
    n_beats = (n_bytes + 63) / 64;
    for (int b = 0; b < n_beats; b++) begin
      d = '0;
      k = '0;
      for (int l = 0; l < 64; l++) begin
        pos = 64 * b + l;
        if (pos < n_bytes) begin
          k[l]         = 1'b1;
          d[8*l +: 8]  = (pos < 58) ? hb[pos] : psn[7:0];
        end
      end
      exp_data.push_back(d);
      exp_keep.push_back(k);
      exp_last.push_back(b == n_beats - 1);
    end
    if (is_rd) exp_rd++;
    else exp_ack++;
  endtask

  // called and returns at a falling edge
  task automatic send_beat(input rdma_resp_pkg::beat_t beat, input logic last);
    logic taken;
    req_tdata_i  = beat;
    req_tvalid_i = 1'b1;
    req_tlast_i  = last;
    taken        = 1'b0;
    while (!taken) begin
      @(posedge core_clk);
      taken = req_tready_o;
      @(negedge core_clk);
    end
  endtask

  task automatic send_request(input logic [7:0] opc, input logic [23:0] qpn,
                              input logic [23:0] psn, input int n_beats);
    for (int i = 0; i < n_beats; i++) begin
      if (i == 0) send_beat(make_req(opc, qpn, psn), n_beats == 1);
      else send_beat({16{32'hdead_0c0a}}, i == n_beats - 1);  // payload filler
    end
    req_tvalid_i = 1'b0;
    req_tlast_i  = 1'b0;
  endtask

  task automatic issue_request(input logic is_rd, input logic [23:0] qpn,
                               input logic [23:0] psn, input int n_beats);
    expect_response(is_rd, qpn, psn);
    send_request(is_rd ? 8'h0C : 8'h0A, qpn, psn, n_beats);
  endtask

  task automatic wait_drain();
    while (exp_data.size() != 0) @(negedge core_clk);
  endtask

  // output monitor
  always @(posedge core_clk) begin
    if (core_aresetn && m_tvalid_o && m_tready_i) begin
      if (exp_data.size() == 0) begin
        $display("unexpected output beat at %0t with nothing expected", $time);
        errors++;
      end else begin
        e_data = exp_data.pop_front();
        e_keep = exp_keep.pop_front();
        e_last = exp_last.pop_front();
        e_mask = keep_to_mask(e_keep);
        assert ((m_tdata_o & e_mask) == e_data) else begin
          $display("Fail %0t: data of output beat %0d differs", $time, beats_seen);
          errors++;
        end
        assert (m_tkeep_o == e_keep) else begin
          $display("Fail %0t: tkeep of output beat %0d is %h", $time, beats_seen, m_tkeep_o);
          errors++;
        end
        assert (m_tlast_o == e_last) else begin
          $display("Fail %0t: tlast of output beat %0d is %b", $time, beats_seen, m_tlast_o);
          errors++;
        end
        beats_seen++;
      end
    end
  end

  initial begin
    m_tready_i = 1'b1;
    forever begin
      @(negedge core_clk);
      m_tready_i = rand_ready ? (($random(seed) & 3) != 0) : 1'b1;
    end
  end

  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge core_clk);
      cycles++;
    end
    $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
    $display("TB FAILED");
    $finish;
  end

  initial begin
    seed         = 80;
    errors       = 0;
    beats_seen   = 0;
    exp_rd       = 0;
    exp_ack      = 0;
    rand_ready   = 1'b0;
    enable_i     = 1'b1;
    req_tdata_i  = '0;
    req_tvalid_i = 1'b0;
    req_tlast_i  = 1'b0;
    local_cfg    = {48'h02_00_5e_00_00_aa, 32'hc0a8_0101};
    for (int i = 0; i < 6; i++) begin
      qp_table[i] = {48'h0c_42_a1_00_10_00 + 48'(i * 17), 32'hc0a8_0120 + 32'(i * 3)};
    end
    for (int i = 0; i < 12; i++) begin
      psn_tab[i] = rdma_resp_pkg::psn_t'($random(seed));
    end
    @(posedge core_aresetn);
    @(negedge core_clk);

    issue_request(1'b1, 24'd3, psn_tab[0], 1);  // read to QP 3
    wait_drain();
    issue_request(1'b0, 24'd1, psn_tab[1], 2);  // write-only with one payload beat
    wait_drain();

    // unknown opcode and out-of-range QPs are dropped
    send_request(8'h04, 24'd1, psn_tab[2], 2);
    send_request(8'h0C, 24'd6, psn_tab[2], 1);
    send_request(8'h0A, 24'd9, psn_tab[2], 2);
    send_request(8'h0C, 24'h000103, psn_tab[2], 1);
    repeat (20) @(negedge core_clk);
    assert (req_tready_o) else begin
      $display("Fail %0t: request input not ready after dropped requests", $time);
      errors++;
    end

    rand_ready = 1'b1;
    issue_request(1'b1, 24'd0, psn_tab[3], 1);
    issue_request(1'b0, 24'd5, psn_tab[4], 2);
    issue_request(1'b1, 24'd2, psn_tab[5], 1);
    issue_request(1'b1, 24'd4, psn_tab[6], 1);
    issue_request(1'b0, 24'd3, psn_tab[7], 1);
    issue_request(1'b0, 24'd0, psn_tab[8], 3);
    issue_request(1'b1, 24'd5, psn_tab[9], 1);
    issue_request(1'b0, 24'd2, psn_tab[10], 1);
    wait_drain();
    rand_ready = 1'b0;
    @(negedge core_clk);
    assert (rd_resp_cnt_o == exp_rd[7:0] && ack_cnt_o == exp_ack[7:0]) else begin
      $display("Fail %0t: counters rd %0d ack %0d, model rd %0d ack %0d", $time,
               rd_resp_cnt_o, ack_cnt_o, exp_rd, exp_ack);
      errors++;
    end

    // held off by enable_i
    enable_i     = 1'b0;
    req_tdata_i  = make_req(8'h0C, 24'd1, psn_tab[11]);
    req_tvalid_i = 1'b1;
    req_tlast_i  = 1'b1;
    repeat (20) begin
      @(posedge core_clk);
      assert (!req_tready_o) else begin
        $display("Fail %0t: req_tready_o high while disabled", $time);
        errors++;
      end
      @(negedge core_clk);
    end
    enable_i = 1'b1;
    issue_request(1'b1, 24'd1, psn_tab[11], 1);
    wait_drain();

    $display("beats checked %0d, rd responses %0d, acks %0d, errors %0d",
             beats_seen, exp_rd, exp_ack, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verif/tb_clk_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen (
  output logic core_clk,
  output logic core_aresetn
);

  initial begin
    core_clk = 1'b0;
    forever #2 core_clk = ~core_clk;  // 4 ns period
  end

  initial begin
    core_aresetn = 1'b0;
    repeat (10) @(posedge core_clk);
    @(negedge core_clk);
    core_aresetn = 1'b1;
  end

endmodule

`default_nettype wire
